/* build.f */
logic/axis_pkg.sv
logic/timing_pkg.sv
logic/sample_sequencer.sv
logic/axis_comparator.sv
logic/motion_accumulator.sv
logic/display_hold.sv
logic/npu_top.sv
verif/npu_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module npu_tb -o npu_sim

./obj_dir/npu_sim 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi

if ! grep -q "Verification passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

/* verif/npu_input.txt */
// word 0 is the line count, then one line per burst, all hex:
// len x0 dx y0 dy z0 dz gap stop leds_on leds_clear (steps in two's complement)
0007
// idle after reset
0000 0000 0000 0000 0000 0000 0000 0003 0000 0000 0000
// x falling, first primes, 89 compares light left
005A 1000 FFFF 0000 0000 0000 0000 0003 0000 0001 0000
// all axes flat
005A 1234 0000 1234 0000 1234 0000 0003 0001 0000 0000
// y rising with z falling, forward and down in one display
005A 1234 0000 0100 0001 0200 FFFF 0003 0001 0018 0000
// x rising once every 251 cycles, leaks away each gap
0004 2000 0001 0000 0000 0000 0000 00FA 0001 0000 0000
// after stop, 89 samples give 88 compares, no fire
0059 3000 0001 0000 0000 0000 0000 0003 0001 0000 0000
// no stop, first sample refills the leak of the hold wait, second fires right
0002 3059 0001 0000 0000 0000 0000 0003 0000 0002 0000

/* verif/npu_tb.sv */
`timescale 1ns/100ps

module npu_tb;

  logic                     clock;
  logic                     reset_n;
  logic                     sample_valid;
  logic                     stop;
  axis_pkg::sample_t        x_in;
  axis_pkg::sample_t        y_in;
  axis_pkg::sample_t        z_in;
  axis_pkg::direction_vec_t leds;

  // word 0 holds the line count, 11 words per line after it
  logic [15:0] stim_mem [0:255];

  int cycle_count = 0;
  int cycle_limit = 0; // zero until the file is read
  int num_lines;

  npu_top u_npu_top (
    .clock          (clock),
    .reset_n        (reset_n),
    .i_sample_valid (sample_valid),
    .i_stop         (stop),
    .i_x            (x_in),
    .i_y            (y_in),
    .i_z            (z_in),
    .o_leds         (leds)
  );

  always #10 clock = ~clock; // 20 ns period

  // watchdog
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $fatal(1, "simulation timed out");
    end
  end

  // one stimulus word, zero extended
  function automatic int fetch_word(input int offset);
    return int'(stim_mem[8'(offset)]);
  endfunction

  task automatic check_leds_on(input axis_pkg::direction_vec_t expected);
    if (leds !== expected) begin
      $display("Fail at %0d ns: LEDs after burst expected %b, got %b",
               $time, expected, leds);
      $display("Verification failed");
      $fatal(1, "LED pattern wrong after burst");
    end
  endtask

  task automatic check_leds_clear(input axis_pkg::direction_vec_t expected);
    if (leds !== expected) begin
      $display("Fail at %0d ns: LEDs after hold expected %b, got %b",
               $time, expected, leds);
      $display("Verification failed");
      $fatal(1, "LED pattern wrong after hold");
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clock);
  endtask

  // one-cycle stop pulse, sequencer must sit in PRIMED
  task automatic apply_stop();
    stop = 1'b1;
    @(negedge clock);
    stop = 1'b0;
    @(negedge clock);
  endtask

  task automatic send_sample(input axis_pkg::sample_t x, input axis_pkg::sample_t y,
                             input axis_pkg::sample_t z);
    sample_valid = 1'b1;
    x_in         = x;
    y_in         = y;
    z_in         = z;
    @(negedge clock);
    sample_valid = 1'b0; // strobe lasts one cycle
  endtask

  task automatic run_burst(input int len, input int gap,
                           input axis_pkg::sample_t x0, input axis_pkg::sample_t dx,
                           input axis_pkg::sample_t y0, input axis_pkg::sample_t dy,
                           input axis_pkg::sample_t z0, input axis_pkg::sample_t dz);
    axis_pkg::sample_t x_val;
    axis_pkg::sample_t y_val;
    axis_pkg::sample_t z_val;
    int                n;

    x_val = x0;
    y_val = y0;
    z_val = z0;
    for (n = 0; n < len; n++) begin
      send_sample(x_val, y_val, z_val);
      wait_cycles(gap);
      x_val = x_val + dx; // wraps like the sensor word
      y_val = y_val + dy;
      z_val = z_val + dz;
    end
  endtask

  initial begin
    int base;
    int line;
    int total;

    clock        = 1'b0;
    reset_n      = 1'b0;
    sample_valid = 1'b0;
    stop         = 1'b0;
    x_in         = '0;
    y_in         = '0;
    z_in         = '0;

    $readmemh("verif/npu_input.txt", stim_mem);
    num_lines = fetch_word(0);
    if (num_lines == 0 || num_lines > 23) begin
      $display("Stimulus file verif/npu_input.txt is missing, empty or too long");
      $display("Verification failed");
      $fatal(1, "no usable stimulus");
    end

    // two passes over every burst, plus a hold and a few spare cycles per line
    total = 0;
    for (line = 0; line < num_lines; line++) begin
      base  = 1 + line * 11;
      total = total + 2 * fetch_word(base) * (fetch_word(base + 7) + 1);
      total = total + timing_pkg::SECOND_CYCLES + 10;
    end
    cycle_limit = total + 20; // reset cycles

    repeat (5) @(negedge clock);
    reset_n = 1'b1;

    for (line = 0; line < num_lines; line++) begin
      base = 1 + line * 11;
      if (fetch_word(base + 8) != 0) begin
        apply_stop();
      end
      run_burst(fetch_word(base), fetch_word(base + 7),
                axis_pkg::sample_t'(fetch_word(base + 1)),
                axis_pkg::sample_t'(fetch_word(base + 2)),
                axis_pkg::sample_t'(fetch_word(base + 3)),
                axis_pkg::sample_t'(fetch_word(base + 4)),
                axis_pkg::sample_t'(fetch_word(base + 5)),
                axis_pkg::sample_t'(fetch_word(base + 6)));
      check_leds_on(axis_pkg::direction_vec_t'(fetch_word(base + 9)));
      wait_cycles(timing_pkg::SECOND_CYCLES + 5); // display hold runs out
      check_leds_clear(axis_pkg::direction_vec_t'(fetch_word(base + 10)));
    end

    $display("Verification passed");
    $finish;
  end

endmodule: npu_tb

/* logic/npu_top.sv */
`timescale 1ns/100ps

module npu_top (
  input  logic                     clock,
  input  logic                     reset_n,
  input  logic                     i_sample_valid,
  input  logic                     i_stop,
  input  axis_pkg::sample_t        i_x,
  input  axis_pkg::sample_t        i_y,
  input  axis_pkg::sample_t        i_z,
  output axis_pkg::direction_vec_t o_leds
);

  logic capture; // shared by all three axes
  logic compare;

  axis_pkg::direction_vec_t activation; // comparator -> accumulator
  axis_pkg::direction_vec_t fired;      // accumulator -> display

  sample_sequencer u_sequencer (
    .clock          (clock),
    .reset_n        (reset_n),
    .i_sample_valid (i_sample_valid),
    .i_stop         (i_stop),
    .o_capture      (capture),
    .o_compare      (compare)
  );

  axis_comparator u_x_axis (
    .clock           (clock),
    .reset_n         (reset_n),
    .i_capture       (capture),
    .i_compare       (compare),
    .i_sample        (i_x),
    .o_move_negative (activation[axis_pkg::dir_left]),
    .o_move_positive (activation[axis_pkg::dir_right])
  );

  axis_comparator u_y_axis (
    .clock           (clock),
    .reset_n         (reset_n),
    .i_capture       (capture),
    .i_compare       (compare),
    .i_sample        (i_y),
    .o_move_negative (activation[axis_pkg::dir_back]),
    .o_move_positive (activation[axis_pkg::dir_forward])
  );

  axis_comparator u_z_axis (
    .clock           (clock),
    .reset_n         (reset_n),
    .i_capture       (capture),
    .i_compare       (compare),
    .i_sample        (i_z),
    .o_move_negative (activation[axis_pkg::dir_down]),
    .o_move_positive (activation[axis_pkg::dir_up])
  );

  // one accumulator per direction bit
  for (genvar d = 0; d < axis_pkg::NUM_DIRECTIONS; d++) begin : g_direction
    motion_accumulator u_accum (
      .clock      (clock),
      .reset_n    (reset_n),
      .i_activate (activation[d]),
      .o_fire     (fired[d])
    );
  end

  display_hold u_display (
    .clock   (clock),
    .reset_n (reset_n),
    .i_fired (fired),
    .o_leds  (o_leds)
  );

endmodule: npu_top

/* logic/display_hold.sv */
`timescale 1ns/100ps

module display_hold (
  input  logic                     clock,
  input  logic                     reset_n,
  input  axis_pkg::direction_vec_t i_fired, // fire pulses, one bit per direction
  output axis_pkg::direction_vec_t o_leds
);

  enum logic {CLEAR, SHOW} state, next_state;

  timing_pkg::period_count_t hold_count;

  logic hold_done;
  logic led_load;
  logic led_clear;

  // LEDs stay up for SECOND_CYCLES cycles after the load edge
  assign hold_done =
    (hold_count == timing_pkg::period_count_t'(timing_pkg::SECOND_CYCLES - 1));

  always_comb begin
    next_state = state;
    led_load   = 1'b0;
    led_clear  = 1'b0;

    case (state)
      CLEAR: begin
        if (i_fired != '0) begin
          next_state = SHOW;
          led_load   = 1'b1;
        end
      end

      SHOW: begin
        // new fires are ignored until the hold ends
        if (hold_done) begin
          next_state = CLEAR;
          led_clear  = 1'b1;
        end
      end

      default: begin
        next_state = CLEAR;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state      <= CLEAR;
      hold_count <= '0;
      o_leds     <= '0;
    end
    else begin
      state <= next_state;
      if (led_load) begin
        o_leds     <= i_fired;
        hold_count <= '0;
      end
      else if (led_clear) begin
        o_leds     <= '0;
        hold_count <= '0;
      end
      else if (state == SHOW) begin
        hold_count <= hold_count + 1'b1;
      end
    end
  end

endmodule: display_hold

/* logic/motion_accumulator.sv */
`timescale 1ns/100ps

module motion_accumulator (
  input  logic clock,
  input  logic reset_n,
  input  logic i_activate, // one activation pulse from a comparator
  output logic o_fire      // to display hold
);

  timing_pkg::period_count_t decay_timer;
  timing_pkg::accum_t        count;

  logic period_done; // a full period passed with no activation
  logic count_up;
  logic count_down;
  logic count_clear;
  logic timer_restart;

  assign period_done =
    (decay_timer == timing_pkg::period_count_t'(timing_pkg::SECOND_CYCLES - 1));

  // high for the single cycle the count sits at threshold
  assign o_fire = (count == timing_pkg::accum_t'(timing_pkg::FIRE_THRESHOLD));

  always_comb begin
    count_up      = 1'b0;
    count_down    = 1'b0;
    count_clear   = 1'b0;
    timer_restart = 1'b0;

    if (o_fire) begin
      count_clear = 1'b1; // fire once, then start over
    end
    else if (i_activate) begin
      count_up      = 1'b1;
      timer_restart = 1'b1;
    end
    else if (period_done) begin
      timer_restart = 1'b1;
      if (count != '0) begin
        count_down = 1'b1; // leak, saturating at zero
      end
    end
  end

  // decay timer
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      decay_timer <= '0;
    end
    else if (timer_restart) begin
      decay_timer <= '0;
    end
    else begin
      decay_timer <= decay_timer + 1'b1;
    end
  end

  // activation count
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      count <= '0;
    end
    else if (count_clear) begin
      count <= '0;
    end
    else if (count_up) begin
      count <= count + 1'b1;
    end
    else if (count_down) begin
      count <= count - 1'b1;
    end
  end

endmodule: motion_accumulator

/* logic/axis_comparator.sv */
`timescale 1ns/100ps

module axis_comparator (
  input  logic              clock,
  input  logic              reset_n,
  input  logic              i_capture,       // from sequencer
  input  logic              i_compare,       // from sequencer
  input  axis_pkg::sample_t i_sample,
  output logic              o_move_negative, // left / back / down
  output logic              o_move_positive  // right / forward / up
);

  axis_pkg::sample_t current_sample;
  axis_pkg::sample_t previous_sample;

  logic is_lower;
  logic is_higher;

  // two-deep sample history
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      current_sample  <= '0;
      previous_sample <= '0;
    end
    else if (i_capture) begin
      previous_sample <= current_sample;
      current_sample  <= i_sample;
    end
  end

  // signed compare, sample_t is two's complement
  always_comb begin
    is_lower  = 1'b0;
    is_higher = 1'b0;

    if (current_sample < previous_sample) begin
      is_lower = 1'b1;
    end
    else if (current_sample > previous_sample) begin
      is_higher = 1'b1;
    end
  end

  // only valid while the sequencer says compare
  assign o_move_negative = i_compare & is_lower;
  assign o_move_positive = i_compare & is_higher;

endmodule: axis_comparator

/* logic/sample_sequencer.sv */
`timescale 1ns/100ps

module sample_sequencer (
  input  logic clock,
  input  logic reset_n,
  input  logic i_sample_valid, // one-cycle strobe with x, y, z
  input  logic i_stop,
  output logic o_capture,      // load sample into all comparators
  output logic o_compare       // comparators evaluate this cycle
);

  enum logic [1:0] {WAITING, PRIMED, COMPARE} state, next_state;

  // next state and capture strobe
  always_comb begin
    next_state = state;
    o_capture  = 1'b0;

    case (state)
      WAITING: begin
        if (i_sample_valid) begin
          next_state = PRIMED;
          o_capture  = 1'b1; // first sample only primes the registers
        end
      end

      PRIMED: begin
        if (i_stop) begin
          next_state = WAITING;
        end
        else if (i_sample_valid) begin
          next_state = COMPARE;
          o_capture  = 1'b1;
        end
      end

      COMPARE: begin
        // strobe arriving here is dropped
        next_state = PRIMED;
      end

      default: begin
        next_state = WAITING;
      end
    endcase
  end

  // compare lasts exactly the one cycle spent in COMPARE
  assign o_compare = (state == COMPARE);

  always_ff @(posedge clock) begin
    if (!reset_n) begin
      state <= WAITING;
    end
    else begin
      state <= next_state;
    end
  end

endmodule: sample_sequencer

/* logic/timing_pkg.sv */
package timing_pkg;

  // cycles in one decay / display period
  // set to the clock rate for a one second period on hardware
  localparam int SECOND_CYCLES = 200;
  localparam int PERIOD_WIDTH  = $clog2(SECOND_CYCLES + 1);

  typedef logic [PERIOD_WIDTH-1:0] period_count_t;

  // activation count at which a direction fires
  localparam int FIRE_THRESHOLD = 89;
  localparam int ACCUM_WIDTH    = 7;

  typedef logic [ACCUM_WIDTH-1:0] accum_t;

endpackage: timing_pkg

/* logic/axis_pkg.sv */
package axis_pkg;

  // raw accelerometer reading, two's complement
  typedef logic signed [15:0] sample_t;

  localparam int NUM_DIRECTIONS = 6;

  // each value doubles as its bit position in direction_vec_t
  typedef enum logic [2:0] {
    dir_left    = 3'd0, // x falling
    dir_right   = 3'd1, // x rising
    dir_back    = 3'd2, // y falling
    dir_forward = 3'd3, // y rising
    dir_down    = 3'd4, // z falling
    dir_up      = 3'd5  // z rising
  } direction_e;

  // one bit per direction
  // used for activations, fires and the LED pattern
  typedef logic [NUM_DIRECTIONS-1:0] direction_vec_t;

endpackage: axis_pkg
